// ==== cpuDatapathPkg.sv ====
`default_nettype none

package cpuDatapathPkg;

  // datapath word and register file geometry
  localparam int dataWidth = 32;
  localparam int regCount = 16;
  localparam int regIndexWidth = 4;

  // one driver of the internal bus per cycle
  typedef enum logic [3:0] {
    srcNone,
    srcReg,
    srcHi,
    srcLo,
    srcZHi,
    srcZLo,
    srcPc,
    srcMdr,
    srcInPort,
    srcY
  } busSrcT;

  // alu opcodes, Y is operand A and the bus is operand B
  typedef enum logic [3:0] {
    opAdd,
    opSub,
    opAnd,
    opOr,
    opShl,
    opShr,
    opNeg,
    opNot,
    opMul
  } aluOpT;

endpackage

`default_nettype wire

// ==== memBusPkg.sv ====
`default_nettype none

package memBusPkg;

  // wishbone word addressing into the shared ram
  localparam int wbAddrWidth = 8;
  localparam int wbDataWidth = 32;
  localparam int memDepth = 256;

  // mar/mdr side bus master
  typedef enum logic {
    msIdle,
    msBusy
  } memIfStateT;

  // current owner of the shared slave
  typedef enum logic [1:0] {
    ownNone,
    ownCore,
    ownHost
  } arbStateT;

endpackage

`default_nettype wire

// ==== registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile
  import cpuDatapathPkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     regIn,
  input  wire logic [regIndexWidth-1:0] regSel,
  input  wire logic                     baOut,
  input  wire logic [dataWidth-1:0]     busIn,
  output logic      [dataWidth-1:0]     regValue
);

  logic [dataWidth-1:0] regs [regCount];

  // single write port from the bus
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (regIn) begin
      regs[regSel] <= busIn;
    end
  end

  // R0 forced to zero for base address use
  always_comb begin
    if (baOut && (regSel == '0)) begin
      regValue = '0;
    end else begin
      regValue = regs[regSel];
    end
  end

  // a write with a floating select would corrupt an unknown register
  regSelKnown: assert property (@(posedge clk) disable iff (reset)
    regIn |-> !$isunknown(regSel));

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
  import cpuDatapathPkg::*;
(
  input  wire logic [dataWidth-1:0]   opA,
  input  wire logic [dataWidth-1:0]   opB,
  input  wire aluOpT                  aluOp,
  output logic      [2*dataWidth-1:0] result
);

  localparam int shiftBits = $clog2(dataWidth);

  logic        [dataWidth-1:0]   lowRes;
  logic signed [2*dataWidth-1:0] product;

  // full signed product for the multiply path
  assign product = $signed(opA) * $signed(opB);

  always_comb begin
    case (aluOp)
      opAdd:   lowRes = opA + opB;
      opSub:   lowRes = opA - opB;
      opAnd:   lowRes = opA & opB;
      opOr:    lowRes = opA | opB;
      // shift amount from low bits of B only
      opShl:   lowRes = opA << opB[shiftBits-1:0];
      opShr:   lowRes = opA >> opB[shiftBits-1:0];
      // unary ops take the bus operand
      opNeg:   lowRes = -opB;
      opNot:   lowRes = ~opB;
      default: lowRes = '0;
    endcase
  end

  // only mul fills the upper half
  always_comb begin
    if (aluOp == opMul) begin
      result = product;
    end else begin
      result = {{dataWidth{1'b0}}, lowRes};
    end
  end

endmodule

`default_nettype wire

// ==== datapathCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathCore
  import cpuDatapathPkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire busSrcT                   busSrc,
  input  wire logic [regIndexWidth-1:0] regSel,
  input  wire logic                     baOut,
  input  wire logic                     regIn,
  input  wire logic                     hiIn,
  input  wire logic                     loIn,
  input  wire logic                     yIn,
  input  wire logic                     zIn,
  input  wire logic                     pcIn,
  input  wire logic                     incPc,
  input  wire logic                     outPortIn,
  input  wire aluOpT                    aluOp,
  input  wire logic [dataWidth-1:0]     inPortData,
  input  wire logic [dataWidth-1:0]     mdrValue,
  output logic      [dataWidth-1:0]     busValue,
  output logic      [dataWidth-1:0]     outPort
);

  logic [dataWidth-1:0]   regValue;
  logic [dataWidth-1:0]   yReg, hiReg, loReg, pcReg, inPortReg;
  logic [dataWidth-1:0]   zHiReg, zLoReg;
  logic [2*dataWidth-1:0] aluResult;

  registerFile regFile (
    .clk      (clk),
    .reset    (reset),
    .regIn    (regIn),
    .regSel   (regSel),
    .baOut    (baOut),
    .busIn    (busValue),
    .regValue (regValue)
  );

  // Y is always operand A
  alu aluUnit (
    .opA    (yReg),
    .opB    (busValue),
    .aluOp  (aluOp),
    .result (aluResult)
  );

  // bus multiplexer
  always_comb begin
    case (busSrc)
      srcReg:    busValue = regValue;
      srcHi:     busValue = hiReg;
      srcLo:     busValue = loReg;
      srcZHi:    busValue = zHiReg;
      srcZLo:    busValue = zLoReg;
      srcPc:     busValue = pcReg;
      srcMdr:    busValue = mdrValue;
      srcInPort: busValue = inPortReg;
      srcY:      busValue = yReg;
      default:   busValue = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      yReg      <= '0;
      zHiReg    <= '0;
      zLoReg    <= '0;
      hiReg     <= '0;
      loReg     <= '0;
      pcReg     <= '0;
      inPortReg <= '0;
      outPort   <= '0;
    end else begin
      // input port free-runs
      inPortReg <= inPortData;
      if (yIn) yReg <= busValue;
      if (hiIn) hiReg <= busValue;
      if (loIn) loReg <= busValue;
      if (outPortIn) outPort <= busValue;
      if (zIn) {zHiReg, zLoReg} <= aluResult;
      // increment wins over a bus load
      if (incPc) begin
        pcReg <= pcReg + 1'b1;
      end else if (pcIn) begin
        pcReg <= busValue;
      end
    end
  end

  // HI/LO take Z contents over the bus, so they cannot load as Z does
  zNotWithHiLo: assert property (@(posedge clk) disable iff (reset)
    zIn |-> !(hiIn || loIn));

endmodule

`default_nettype wire

// ==== memoryInterface.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryInterface
  import memBusPkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   marIn,
  input  wire logic                   mdrIn,
  input  wire logic                   memRead,
  input  wire logic                   memWrite,
  input  wire logic [wbDataWidth-1:0] busValue,
  input  wire logic [wbDataWidth-1:0] wbDatR,
  input  wire logic                   wbAck,
  output logic      [wbDataWidth-1:0] mdrValue,
  output logic                        memBusy,
  output logic                        memDone,
  output logic                        wbCyc,
  output logic                        wbStb,
  output logic                        wbWe,
  output logic      [wbAddrWidth-1:0] wbAdr,
  output logic      [wbDataWidth-1:0] wbDatW
);

  memIfStateT state;
  logic [wbAddrWidth-1:0] mar;
  logic [wbDataWidth-1:0] mdr;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= msIdle;
      wbWe    <= 1'b0;
      memDone <= 1'b0;
      mar     <= '0;
      mdr     <= '0;
    end else begin
      memDone <= 1'b0;
      // word address from low bus bits
      if (marIn) mar <= busValue[wbAddrWidth-1:0];
      if (mdrIn) mdr <= busValue;
      case (state)
        msIdle: begin
          if (memRead || memWrite) begin
            state <= msBusy;
            wbWe  <= memWrite;
          end
        end
        msBusy: begin
          if (wbAck) begin
            state   <= msIdle;
            memDone <= 1'b1;
            // completed read overrides a bus load
            if (!wbWe) mdr <= wbDatR;
          end
        end
        default: state <= msIdle;
      endcase
    end
  end

  // cyc and stb held for the whole busy phase
  assign memBusy  = (state == msBusy);
  assign wbCyc    = memBusy;
  assign wbStb    = memBusy;
  assign wbAdr    = mar;
  assign wbDatW   = mdr;
  assign mdrValue = mdr;

  readWriteExclusive: assert property (@(posedge clk) disable iff (reset)
    !(memRead && memWrite));

endmodule

`default_nettype wire

// ==== wbArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbArbiter
  import memBusPkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   coreCyc,
  input  wire logic                   coreStb,
  input  wire logic                   coreWe,
  input  wire logic [wbAddrWidth-1:0] coreAdr,
  input  wire logic [wbDataWidth-1:0] coreDatW,
  input  wire logic                   hostCyc,
  input  wire logic                   hostStb,
  input  wire logic                   hostWe,
  input  wire logic [wbAddrWidth-1:0] hostAdr,
  input  wire logic [wbDataWidth-1:0] hostDatW,
  input  wire logic [wbDataWidth-1:0] memDatR,
  input  wire logic                   memAck,
  output logic                        coreAck,
  output logic      [wbDataWidth-1:0] coreDatR,
  output logic                        hostAck,
  output logic      [wbDataWidth-1:0] hostDatR,
  output logic                        memCyc,
  output logic                        memStb,
  output logic                        memWe,
  output logic      [wbAddrWidth-1:0] memAdr,
  output logic      [wbDataWidth-1:0] memDatW
);

  arbStateT owner, grant;

  // keep current owner while its cyc stays up, else core first
  always_comb begin
    if (owner == ownCore && coreCyc) begin
      grant = ownCore;
    end else if (owner == ownHost && hostCyc) begin
      grant = ownHost;
    end else if (coreCyc) begin
      grant = ownCore;
    end else if (hostCyc) begin
      grant = ownHost;
    end else begin
      grant = ownNone;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= ownNone;
    end else begin
      owner <= grant;
    end
  end

  // slave side mux
  always_comb begin
    memCyc  = 1'b0;
    memStb  = 1'b0;
    memWe   = 1'b0;
    memAdr  = '0;
    memDatW = '0;
    if (grant == ownCore) begin
      {memCyc, memStb, memWe} = {coreCyc, coreStb, coreWe};
      memAdr  = coreAdr;
      memDatW = coreDatW;
    end else if (grant == ownHost) begin
      {memCyc, memStb, memWe} = {hostCyc, hostStb, hostWe};
      memAdr  = hostAdr;
      memDatW = hostDatW;
    end
  end

  // stalled master sees no ack
  assign coreAck  = memAck && (grant == ownCore);
  assign hostAck  = memAck && (grant == ownHost);
  assign coreDatR = (grant == ownCore) ? memDatR : '0;
  assign hostDatR = (grant == ownHost) ? memDatR : '0;

  // ack goes back to the master that started the access
  ackToRequester: assert property (@(posedge clk) disable iff (reset)
    memAck |-> (grant != ownNone && grant == $past(grant)));

endmodule

`default_nettype wire

// ==== wbMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbMemory
  import memBusPkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   memCyc,
  input  wire logic                   memStb,
  input  wire logic                   memWe,
  input  wire logic [wbAddrWidth-1:0] memAdr,
  input  wire logic [wbDataWidth-1:0] memDatW,
  output logic      [wbDataWidth-1:0] memDatR,
  output logic                        memAck
);

  logic [wbDataWidth-1:0] mem [memDepth];
  logic                   access;

  // new access only when the previous ack has gone
  assign access = memCyc && memStb && !memAck;

  always_ff @(posedge clk) begin
    if (reset) begin
      memAck <= 1'b0;
    end else begin
      memAck <= access;
    end
  end

  // ram array and read data
  always_ff @(posedge clk) begin
    if (access) begin
      if (memWe) mem[memAdr] <= memDatW;
      memDatR <= mem[memAdr];
    end
  end

endmodule

`default_nettype wire

// ==== cpuSystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuSystem
  import cpuDatapathPkg::*, memBusPkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire busSrcT                   busSrc,
  input  wire logic [regIndexWidth-1:0] regSel,
  input  wire logic                     baOut,
  input  wire logic                     regIn,
  input  wire logic                     hiIn,
  input  wire logic                     loIn,
  input  wire logic                     yIn,
  input  wire logic                     zIn,
  input  wire logic                     pcIn,
  input  wire logic                     incPc,
  input  wire logic                     outPortIn,
  input  wire aluOpT                    aluOp,
  input  wire logic [dataWidth-1:0]     inPortData,
  input  wire logic                     memRead,
  input  wire logic                     memWrite,
  input  wire logic                     marIn,
  input  wire logic                     mdrIn,
  input  wire logic                     hostCyc,
  input  wire logic                     hostStb,
  input  wire logic                     hostWe,
  input  wire logic [wbAddrWidth-1:0]   hostAdr,
  input  wire logic [wbDataWidth-1:0]   hostDatW,
  output logic      [wbDataWidth-1:0]   hostDatR,
  output logic                          hostAck,
  output logic      [dataWidth-1:0]     outPort,
  output logic                          memBusy,
  output logic                          memDone
);

  logic [dataWidth-1:0]   busValue, mdrValue;
  // core master toward arbiter
  logic                   coreCyc, coreStb, coreWe, coreAck;
  logic [wbAddrWidth-1:0] coreAdr;
  logic [wbDataWidth-1:0] coreDatW, coreDatR;
  // arbiter toward ram
  logic                   memCyc, memStb, memWe, memAck;
  logic [wbAddrWidth-1:0] memAdr;
  logic [wbDataWidth-1:0] memDatW, memDatR;

  datapathCore core (
    .clk        (clk),
    .reset      (reset),
    .busSrc     (busSrc),
    .regSel     (regSel),
    .baOut      (baOut),
    .regIn      (regIn),
    .hiIn       (hiIn),
    .loIn       (loIn),
    .yIn        (yIn),
    .zIn        (zIn),
    .pcIn       (pcIn),
    .incPc      (incPc),
    .outPortIn  (outPortIn),
    .aluOp      (aluOp),
    .inPortData (inPortData),
    .mdrValue   (mdrValue),
    .busValue   (busValue),
    .outPort    (outPort)
  );

  memoryInterface memIf (
    .clk      (clk),
    .reset    (reset),
    .marIn    (marIn),
    .mdrIn    (mdrIn),
    .memRead  (memRead),
    .memWrite (memWrite),
    .busValue (busValue),
    .wbDatR   (coreDatR),
    .wbAck    (coreAck),
    .mdrValue (mdrValue),
    .memBusy  (memBusy),
    .memDone  (memDone),
    .wbCyc    (coreCyc),
    .wbStb    (coreStb),
    .wbWe     (coreWe),
    .wbAdr    (coreAdr),
    .wbDatW   (coreDatW)
  );

  wbArbiter arbiter (
    .clk      (clk),
    .reset    (reset),
    .coreCyc  (coreCyc),
    .coreStb  (coreStb),
    .coreWe   (coreWe),
    .coreAdr  (coreAdr),
    .coreDatW (coreDatW),
    .hostCyc  (hostCyc),
    .hostStb  (hostStb),
    .hostWe   (hostWe),
    .hostAdr  (hostAdr),
    .hostDatW (hostDatW),
    .memDatR  (memDatR),
    .memAck   (memAck),
    .coreAck  (coreAck),
    .coreDatR (coreDatR),
    .hostAck  (hostAck),
    .hostDatR (hostDatR),
    .memCyc   (memCyc),
    .memStb   (memStb),
    .memWe    (memWe),
    .memAdr   (memAdr),
    .memDatW  (memDatW)
  );

  wbMemory ram (
    .clk     (clk),
    .reset   (reset),
    .memCyc  (memCyc),
    .memStb  (memStb),
    .memWe   (memWe),
    .memAdr  (memAdr),
    .memDatW (memDatW),
    .memDatR (memDatR),
    .memAck  (memAck)
  );

endmodule

`default_nettype wire

// ==== cpuSystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuSystemTb
  import cpuDatapathPkg::*, memBusPkg::*;
;

  localparam int waitLimit = 50;

  logic clk = 1'b0;
  logic reset;
  busSrcT busSrc;
  logic [regIndexWidth-1:0] regSel;
  logic baOut, regIn, hiIn, loIn, yIn, zIn, pcIn, incPc, outPortIn;
  aluOpT aluOp;
  logic [dataWidth-1:0] inPortData;
  logic memRead, memWrite, marIn, mdrIn;
  logic hostCyc, hostStb, hostWe;
  logic [wbAddrWidth-1:0] hostAdr;
  logic [wbDataWidth-1:0] hostDatW, hostDatR;
  logic hostAck, memBusy, memDone;
  logic [dataWidth-1:0] outPort;

  logic [31:0] rngState = 32'hde1c;
  logic [wbDataWidth-1:0] shadow [memDepth];
  logic timedOut = 1'b0;
  int tests = 0;
  int errors = 0;

  cpuSystem UUT (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // reference alu, Y is a and the bus is b
  function automatic logic [63:0] aluModel(aluOpT op, logic [31:0] a, logic [31:0] b);
    logic [63:0] full;
    case (op)
      opAdd:   full = {32'h0, a + b};
      opSub:   full = {32'h0, a - b};
      opAnd:   full = {32'h0, a & b};
      opOr:    full = {32'h0, a | b};
      opShl:   full = {32'h0, a << b[4:0]};
      opShr:   full = {32'h0, a >> b[4:0]};
      opNeg:   full = {32'h0, -b};
      opNot:   full = {32'h0, ~b};
      // sign extend both, keep low 64 bits of the product
      opMul:   full = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      default: full = '0;
    endcase
    return full;
  endfunction

  task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
    tests++;
    assert (actual === expected) $display("ok   %s", name);
    else begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic checkFlag(string name, logic cond, string what);
    tests++;
    assert (cond === 1'b1) $display("ok   %s", name);
    else begin
      errors++;
      $display("%s: %s", name, what);
    end
  endtask

  task automatic stopOnTimeout(string what);
    $display("timeout while waiting for %s", what);
    timedOut = 1'b1;
    // sequence parks here until the run ends
    forever @(posedge clk);
  endtask

  // a timed out wait ends the run
  initial begin
    wait (timedOut);
    $display("Checks failed");
    $finish;
  end

  // one bus cycle, source plus one load strobe, then idle
  task automatic transfer(busSrcT src, logic [regIndexWidth-1:0] sel, string dest);
    @(posedge clk);
    busSrc    <= src;
    regSel    <= sel;
    regIn     <= (dest == "reg");
    yIn       <= (dest == "y");
    zIn       <= (dest == "z");
    outPortIn <= (dest == "out");
    marIn     <= (dest == "mar");
    mdrIn     <= (dest == "mdr");
    @(posedge clk);
    busSrc    <= srcNone;
    regIn     <= 1'b0;
    yIn       <= 1'b0;
    zIn       <= 1'b0;
    outPortIn <= 1'b0;
    marIn     <= 1'b0;
    mdrIn     <= 1'b0;
  endtask

  // in port register samples one edge later
  task automatic fromInPort(logic [31:0] value, logic [regIndexWidth-1:0] sel, string dest);
    @(posedge clk);
    inPortData <= value;
    transfer(srcInPort, sel, dest);
  endtask

  task automatic readOut(busSrcT src, logic [regIndexWidth-1:0] sel, output logic [31:0] value);
    transfer(src, sel, "out");
    @(negedge clk);
    value = outPort;
  endtask

  task automatic memRequest(logic write);
    int n;
    @(posedge clk);
    memRead  <= !write;
    memWrite <= write;
    @(posedge clk);
    memRead  <= 1'b0;
    memWrite <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!memDone && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!memDone) stopOnTimeout("memDone");
  endtask

  task automatic hostAccess(logic we, logic [wbAddrWidth-1:0] adr, logic [31:0] datW,
                            output logic [31:0] datR);
    int n;
    @(posedge clk);
    hostCyc  <= 1'b1;
    hostStb  <= 1'b1;
    hostWe   <= we;
    hostAdr  <= adr;
    hostDatW <= datW;
    n = 0;
    @(negedge clk);
    while (!hostAck && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!hostAck) begin
      stopOnTimeout("hostAck");
    end else begin
      datR = hostDatR;
      // drop cyc and stb on the edge after ack
      @(posedge clk);
      hostCyc <= 1'b0;
      hostStb <= 1'b0;
      hostWe  <= 1'b0;
    end
  endtask

  // core write and host read of one address, host cyc rises with core cyc
  task automatic contendedWrite(logic [wbAddrWidth-1:0] adr, logic [31:0] word);
    int n, doneAt, ackAt;
    logic [31:0] readBack;
    doneAt = -1;
    ackAt = -1;
    n = 0;
    readBack = '0;
    @(posedge clk);
    memWrite <= 1'b1;
    @(posedge clk);
    memWrite <= 1'b0;
    hostCyc  <= 1'b1;
    hostStb  <= 1'b1;
    hostWe   <= 1'b0;
    hostAdr  <= adr;
    while (ackAt < 0 && n < waitLimit) begin
      @(negedge clk);
      if (memDone && doneAt < 0) doneAt = n;
      if (hostAck) begin
        ackAt = n;
        readBack = hostDatR;
      end
      n++;
    end
    if (ackAt < 0) begin
      stopOnTimeout("hostAck under contention");
    end else begin
      @(posedge clk);
      hostCyc <= 1'b0;
      hostStb <= 1'b0;
      checkFlag("contention order", doneAt >= 0 && doneAt < ackAt,
                "memDone did not pulse before hostAck");
      checkValue("contention data", word, readBack);
    end
  endtask

  initial begin
    logic [31:0] vals [regCount];
    logic [31:0] got, a, b, rnd;
    logic [63:0] model;
    logic [wbAddrWidth-1:0] addrs [4];
    aluOpT op;
    // every DUT input idle, reset high
    reset <= 1'b1;
    busSrc <= srcNone;
    regSel <= '0;
    {baOut, regIn, hiIn, loIn, yIn, zIn, pcIn, incPc, outPortIn} <= '0;
    aluOp <= opAdd;
    inPortData <= '0;
    {memRead, memWrite, marIn, mdrIn} <= '0;
    {hostCyc, hostStb, hostWe} <= '0;
    hostAdr <= '0;
    hostDatW <= '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // reset state and pc increment
    @(negedge clk);
    checkValue("reset outPort", 32'h0, outPort);
    checkFlag("reset handshakes", !memBusy && !memDone && !hostAck,
              "memBusy, memDone or hostAck is high after reset");
    readOut(srcPc, '0, got);
    checkValue("reset pc", 32'h0, got);
    @(posedge clk);
    incPc <= 1'b1;
    repeat (3) @(posedge clk);
    incPc <= 1'b0;
    readOut(srcPc, '0, got);
    checkValue("pc after 3 increments", 32'd3, got);

    // general registers through the in port
    for (int r = 1; r < regCount; r++) begin
      vals[r] = nextRandom();
      fromInPort(vals[r], regIndexWidth'(r), "reg");
    end
    for (int r = 1; r < regCount; r++) begin
      readOut(srcReg, regIndexWidth'(r), got);
      checkValue($sformatf("reg R%0d", r), vals[r], got);
    end
    vals[0] = nextRandom();
    fromInPort(vals[0], '0, "reg");
    @(posedge clk);
    baOut <= 1'b1;
    readOut(srcReg, '0, got);
    checkValue("R0 with baOut", 32'h0, got);
    @(posedge clk);
    baOut <= 1'b0;
    readOut(srcReg, '0, got);
    checkValue("R0 without baOut", vals[0], got);

    // every alu op on a few random operand pairs
    for (int t = 0; t < 3; t++) begin
      a = nextRandom();
      b = nextRandom();
      fromInPort(a, '0, "y");
      for (int k = 0; k <= int'(opMul); k++) begin
        op = aluOpT'(k);
        model = aluModel(op, a, b);
        @(posedge clk);
        aluOp <= op;
        fromInPort(b, '0, "z");
        readOut(srcZLo, '0, got);
        checkValue($sformatf("alu %s lo", op.name()), model[31:0], got);
        if (op == opMul) begin
          readOut(srcZHi, '0, got);
          checkValue("alu opMul hi", model[63:32], got);
        end
      end
    end

    // host fills, datapath reads back through MAR and MDR
    for (int i = 0; i < 4; i++) begin
      rnd = nextRandom();
      addrs[i] = rnd[wbAddrWidth-1:0];
      shadow[addrs[i]] = nextRandom();
      hostAccess(1'b1, addrs[i], shadow[addrs[i]], got);
    end
    for (int i = 0; i < 4; i++) begin
      fromInPort(dataWidth'(addrs[i]), '0, "mar");
      memRequest(1'b0);
      readOut(srcMdr, '0, got);
      checkValue($sformatf("mem read %0d", i), shadow[addrs[i]], got);
    end

    // core write against a host read of the same word
    rnd = nextRandom();
    a = nextRandom();
    fromInPort(dataWidth'(rnd[wbAddrWidth-1:0]), '0, "mar");
    fromInPort(a, '0, "mdr");
    contendedWrite(rnd[wbAddrWidth-1:0], a);

    $display("tests %0d, failures %0d", tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpuSystem.f ====
cpuDatapathPkg.sv
memBusPkg.sv
registerFile.sv
alu.sv
datapathCore.sv
memoryInterface.sv
wbArbiter.sv
wbMemory.sv
cpuSystem.sv
cpuSystemTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpuSystemTb
FILELIST  ?= cpuSystem.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJDIR) -o V$(TOP)

# exit status comes from the search for the pass line
sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
